// ==== logic/isaPkg.sv ====
// instruction-set definitions: opcodes, field positions, instruction kinds, ALU ops, branch conditions
package isaPkg;

    // instruction word layout
    //   III M XXX DDDDDDDDD   immediate form
    //   III M XXX 000000YYY   register form
    localparam int OpcodeBits = 3;
    localparam int OpcodeMsb  = 15;
    localparam int OpcodeLsb  = 13;
    localparam int ImmFlagBit = 12;  // M, immediate operand
    localparam int RxMsb      = 11;
    localparam int RxLsb      = 9;
    localparam int ImmMsb     = 8;   // immediate is bits 8..0
    localparam int ImmBits    = 9;
    localparam int RyMsb      = 2;   // rY when M is clear
    localparam int RyLsb      = 0;
    localparam int MvtByteMsb = 7;   // mvt takes bits 7..0 only

    typedef enum logic [OpcodeBits-1:0] {
        opMv    = 3'b000,
        opMvtB  = 3'b001,  // mvt with M set, branch with M clear
        opAdd   = 3'b010,
        opSub   = 3'b011,
        opLd    = 3'b100,
        opSt    = 3'b101,
        opAnd   = 3'b110,
        opOther = 3'b111   // executes as nop
    } opcodeT;

    // decoded kind, nop first so a cleared payload reads as nop
    typedef enum logic [3:0] {
        nop, mov, mvt, branch, add, sub, load, store, logicAnd
    } instrT;

    typedef enum logic [2:0] {
        aluNone, aluAdd, aluSub, aluAnd, aluPass
    } aluOpT;

    // branch condition sits in the rX field, other codes never taken
    typedef enum logic [2:0] {
        condAlways = 3'b000,
        condEq     = 3'b001,
        condNe     = 3'b010
    } branchCondT;

endpackage

// ==== logic/pipePkg.sv ====
// pipeline definitions: word and register sizes, stage-to-stage payload structs
package pipePkg;

    localparam int WordSize = 16;
    localparam int NumRegs  = 8;
    localparam int RegBits  = $clog2(NumRegs);

    typedef logic [WordSize-1:0] wordT;
    typedef logic [RegBits-1:0]  regIdxT;

    // decode to execute
    typedef struct packed {
        logic               valid;      // clear for nop or bubble
        isaPkg::instrT      instr;
        isaPkg::aluOpT      aluOp;
        regIdxT             rX;         // destination, also first source
        regIdxT             rY;         // second source when imm is clear
        wordT               op1;        // rX value at decode
        wordT               op2;        // rY value or extended immediate
        logic               imm;
        logic               read;       // ld
        logic               write;      // st
        logic               writeback;  // result goes to rX
        isaPkg::branchCondT cond;
        wordT               pc;         // address of this instruction
    } decodedT;

    // execute to memory
    typedef struct packed {
        logic   valid;
        regIdxT rX;
        wordT   result;     // ALU result, data address for ld and st
        wordT   storeData;  // rX value for st
        logic   read;
        logic   write;
        logic   writeback;
    } execT;

    // writeback, also a forwarding source
    typedef struct packed {
        logic   valid;  // set only when rX is really written
        regIdxT rX;
        wordT   data;
    } wbT;

endpackage

// ==== logic/fetchDecode.sv ====
// program counter, fetch register, instruction decode, load-use bubble and branch squash
`timescale 1ns/1ps

module fetchDecode #(
    parameter pipePkg::wordT ResetPc = '0  // first fetch address after reset
) (
    input  logic             Clock,
    input  logic             rstN,
    input  pipePkg::wordT    instrIn,       // valid in the cycle instrAddr is shown
    input  logic             stall,         // memory stage waiting, hold everything
    input  logic             branchTaken,
    input  pipePkg::wordT    branchTarget,
    input  pipePkg::regIdxT  loadInExec,    // destination of the load in execute
    input  logic             loadPending,   // a load sits in execute
    input  pipePkg::wordT    rdData0,
    input  pipePkg::wordT    rdData1,
    output pipePkg::wordT    instrAddr,
    output pipePkg::regIdxT  rdAddr0,
    output pipePkg::regIdxT  rdAddr1,
    output pipePkg::decodedT decOut
);
    import isaPkg::*;
    import pipePkg::*;

    wordT    pc;
    wordT    fetchInstr;   // instruction word in decode
    wordT    fetchPc;      // its address, for branch targets
    logic    fetchValid;   // cleared by reset and squash
    opcodeT  opcode;
    logic    immFlag;
    wordT    immExt;       // zero extended immediate
    wordT    branchOff;    // sign extended immediate
    logic    usesX;
    logic    usesY;
    logic    loadUse;
    decodedT decNext;

    assign instrAddr = pc;  // instruction port is combinational

    assign opcode    = opcodeT'(fetchInstr[OpcodeMsb:OpcodeLsb]);
    assign immFlag   = fetchInstr[ImmFlagBit];
    assign rdAddr0   = fetchInstr[RxMsb:RxLsb];
    assign rdAddr1   = fetchInstr[RyMsb:RyLsb];
    assign immExt    = {{(WordSize-ImmBits){1'b0}}, fetchInstr[ImmMsb:0]};
    assign branchOff = {{(WordSize-ImmBits){fetchInstr[ImmMsb]}}, fetchInstr[ImmMsb:0]};

    always_comb begin
        decNext       = '0;
        decNext.rX    = rdAddr0;
        decNext.rY    = rdAddr1;
        decNext.op1   = rdData0;               // rX read, forwarded later in execute
        decNext.imm   = immFlag;
        decNext.pc    = fetchPc;
        decNext.cond  = branchCondT'(rdAddr0); // only meaningful for branches
        case (opcode)
            opMv: begin
                decNext.instr     = mov;
                decNext.aluOp     = aluPass;
                decNext.writeback = 1'b1;
            end
            opMvtB: begin
                decNext.instr     = immFlag ? mvt : branch;
                decNext.aluOp     = immFlag ? aluPass : aluNone;
                decNext.writeback = immFlag;   // branch writes nothing
                decNext.imm       = 1'b1;      // both forms take the immediate
            end
            opAdd: begin
                decNext.instr     = add;
                decNext.aluOp     = aluAdd;
                decNext.writeback = 1'b1;
            end
            opSub: begin
                decNext.instr     = sub;
                decNext.aluOp     = aluSub;
                decNext.writeback = 1'b1;
            end
            opLd: begin
                decNext.instr     = load;
                decNext.aluOp     = aluPass;   // address is rY
                decNext.read      = 1'b1;
                decNext.writeback = 1'b1;
                decNext.imm       = 1'b0;
            end
            opSt: begin
                decNext.instr     = store;
                decNext.aluOp     = aluPass;
                decNext.write     = 1'b1;
                decNext.imm       = 1'b0;
            end
            opAnd: begin
                decNext.instr     = logicAnd;
                decNext.aluOp     = aluAnd;
                decNext.writeback = 1'b1;
            end
            default: begin
                decNext.instr     = nop;       // opcode 111
            end
        endcase
        if (decNext.imm) begin
            decNext.op2 = (decNext.instr == branch) ? branchOff : immExt;
        end else begin
            decNext.op2 = rdData1;
        end
        // empty slot, all-zero word and opcode 111 leave as a bubble
        if (!fetchValid || fetchInstr == '0 || decNext.instr == nop) begin
            decNext = '0;
        end else begin
            decNext.valid = 1'b1;
        end
    end

    // source registers actually read by this instruction
    assign usesX   = decNext.instr inside {add, sub, logicAnd, store};
    assign usesY   = decNext.valid && !decNext.imm;
    assign loadUse = loadPending && decNext.valid &&
                     ((usesX && decNext.rX == loadInExec) || (usesY && decNext.rY == loadInExec));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc         <= ResetPc;
            fetchValid <= 1'b0;
            decOut     <= '0;
        end else if (!stall) begin
            if (branchTaken) begin
                pc         <= branchTarget;  // redirect
                fetchValid <= 1'b0;          // squash the word being fetched
                decOut     <= '0;            // squash the word being decoded
            end else if (loadUse) begin
                decOut     <= '0;            // bubble, pc and fetch register hold
            end else begin
                pc         <= pc + 1'b1;
                fetchValid <= 1'b1;
                decOut     <= decNext;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!stall && !branchTaken && !loadUse) begin
            fetchInstr <= instrIn;
            fetchPc    <= pc;
        end
    end

endmodule

// ==== logic/regFile.sv ====
// eight-entry register file, two read ports, one write port with write-through
`timescale 1ns/1ps

module regFile (
    input  logic            Clock,
    input  logic            rstN,
    input  pipePkg::regIdxT rdAddr0,
    input  pipePkg::regIdxT rdAddr1,
    input  pipePkg::wbT     wbIn,     // writeback stage result
    output pipePkg::wordT   rdData0,
    output pipePkg::wordT   rdData1
);
    import pipePkg::*;

    wordT regs [NumRegs];  // r0..r7, pc lives in fetch

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbIn.valid) begin
            regs[wbIn.rX] <= wbIn.data;
        end
    end

    // same-cycle write shows through to the reader
    always_comb begin
        if (wbIn.valid && wbIn.rX == rdAddr0) begin
            rdData0 = wbIn.data;
        end else begin
            rdData0 = regs[rdAddr0];
        end
    end

    always_comb begin
        if (wbIn.valid && wbIn.rX == rdAddr1) begin
            rdData1 = wbIn.data;
        end else begin
            rdData1 = regs[rdAddr1];
        end
    end

endmodule

// ==== logic/execUnit.sv ====
// operand forwarding, ALU, zero flag, branch resolution and the execute register
`timescale 1ns/1ps

module execUnit (
    input  logic             Clock,
    input  logic             rstN,
    input  logic             stall,
    input  pipePkg::decodedT decIn,
    input  pipePkg::wbT      memFwd,        // memory stage result, this cycle
    input  pipePkg::wbT      wbFwd,         // writeback register
    output pipePkg::execT    exOut,
    output logic             branchTaken,   // one cycle, squashes fetch and decode
    output pipePkg::wordT    branchTarget,
    output pipePkg::regIdxT  loadInExec,
    output logic             loadPending
);
    import isaPkg::*;
    import pipePkg::*;

    wordT opX;        // forwarded rX value
    wordT opY;        // forwarded rY value or immediate
    wordT aluResult;
    logic zeroFlag;
    logic condMet;

    // newest producer wins: memory stage, then writeback, then decode
    function automatic wordT pickOperand(input regIdxT idx, input wordT fromDecode,
                                         input wbT memStage, input wbT wbStage);
        wordT value;
        value = fromDecode;
        if (wbStage.valid && wbStage.rX == idx) begin
            value = wbStage.data;
        end
        if (memStage.valid && memStage.rX == idx) begin
            value = memStage.data;
        end
        return value;
    endfunction

    assign opX = pickOperand(decIn.rX, decIn.op1, memFwd, wbFwd);
    assign opY = decIn.imm ? decIn.op2 : pickOperand(decIn.rY, decIn.op2, memFwd, wbFwd);

    always_comb begin
        case (decIn.aluOp)
            aluAdd:  aluResult = opX + opY;
            aluSub:  aluResult = opX - opY;
            aluAnd:  aluResult = opX & opY;
            aluPass: begin
                if (decIn.instr == mvt) begin
                    // byte to the top, low byte cleared
                    aluResult = {opY[MvtByteMsb:0], {(MvtByteMsb+1){1'b0}}};
                end else begin
                    aluResult = opY;  // mv, and the ld/st address
                end
            end
            default: aluResult = '0;
        endcase
    end

    always_comb begin
        case (decIn.cond)
            condAlways: condMet = 1'b1;
            condEq:     condMet = zeroFlag;
            condNe:     condMet = !zeroFlag;
            default:    condMet = 1'b0;
        endcase
    end

    assign branchTaken  = !stall && decIn.valid && decIn.instr == branch && condMet;
    assign branchTarget = decIn.pc + 1'b1 + decIn.op2;  // op2 already sign extended

    // decode checks its sources against this
    assign loadInExec  = decIn.rX;
    assign loadPending = decIn.valid && decIn.read;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            zeroFlag <= 1'b0;
            exOut    <= '0;
        end else if (!stall) begin
            if (decIn.valid && decIn.aluOp inside {aluAdd, aluSub, aluAnd}) begin
                zeroFlag <= (aluResult == '0);  // only add, sub and and set it
            end
            exOut.valid     <= decIn.valid;
            exOut.rX        <= decIn.rX;
            exOut.result    <= aluResult;
            exOut.storeData <= opX;             // st writes rX
            exOut.read      <= decIn.read;
            exOut.write     <= decIn.write;
            exOut.writeback <= decIn.writeback;
        end
    end

endmodule

// ==== logic/memWriteback.sv ====
// data-port access under wait request, stall generation and the writeback register
`timescale 1ns/1ps

module memWriteback (
    input  logic          Clock,
    input  logic          rstN,
    input  pipePkg::execT exIn,
    input  pipePkg::wordT dataIn,
    input  logic          dataWaitreq,  // memory not ready, hold the pipeline
    output pipePkg::wordT dataAddr,
    output pipePkg::wordT dataOut,
    output logic          readData,
    output logic          writeData,
    output logic          stall,
    output pipePkg::wbT   memFwd,       // result leaving memory this cycle
    output pipePkg::wbT   wbOut         // writeback register, feeds regFile
);
    import pipePkg::*;

    logic access;  // ld or st in the memory stage

    assign access = exIn.valid && (exIn.read || exIn.write);

    // strobes stay up until the cycle dataWaitreq drops
    assign readData  = exIn.valid && exIn.read;
    assign writeData = exIn.valid && exIn.write;
    assign dataAddr  = exIn.result;
    assign dataOut   = exIn.storeData;

    assign stall = access && dataWaitreq;

    // a load still waiting has nothing to forward yet
    always_comb begin
        memFwd.valid = exIn.valid && exIn.writeback && !stall;
        memFwd.rX    = exIn.rX;
        memFwd.data  = exIn.read ? dataIn : exIn.result;  // ld captures in its last cycle
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wbOut <= '0;
        end else if (!stall) begin
            wbOut <= memFwd;
        end
    end

endmodule

// ==== logic/cpuCore.sv ====
// top level: five-stage core with separate instruction and data ports
`timescale 1ns/1ps

module cpuCore #(
    parameter pipePkg::wordT ResetPc = '0
) (
    input  logic          Clock,
    input  logic          rstN,
    input  pipePkg::wordT instrIn,
    input  pipePkg::wordT dataIn,
    input  logic          dataWaitreq,
    output pipePkg::wordT instrAddr,
    output pipePkg::wordT dataAddr,
    output pipePkg::wordT dataOut,
    output logic          readData,
    output logic          writeData
);
    import pipePkg::*;

    regIdxT  rdAddr0;
    regIdxT  rdAddr1;
    wordT    rdData0;
    wordT    rdData1;
    decodedT decoded;       // decode to execute
    execT    executed;      // execute to memory
    wbT      memFwd;
    wbT      wbOut;
    logic    stall;
    logic    branchTaken;
    wordT    branchTarget;
    regIdxT  loadInExec;
    logic    loadPending;

    // input side: fetch and decode
    fetchDecode #(
        .ResetPc (ResetPc)
    ) u_fetchDecode (
        .Clock        (Clock),
        .rstN         (rstN),
        .instrIn      (instrIn),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .loadInExec   (loadInExec),
        .loadPending  (loadPending),
        .rdData0      (rdData0),
        .rdData1      (rdData1),
        .instrAddr    (instrAddr),
        .rdAddr0      (rdAddr0),
        .rdAddr1      (rdAddr1),
        .decOut       (decoded)
    );

    regFile u_regFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .rdAddr0 (rdAddr0),
        .rdAddr1 (rdAddr1),
        .wbIn    (wbOut),
        .rdData0 (rdData0),
        .rdData1 (rdData1)
    );

    execUnit u_execUnit (
        .Clock        (Clock),
        .rstN         (rstN),
        .stall        (stall),
        .decIn        (decoded),
        .memFwd       (memFwd),
        .wbFwd        (wbOut),
        .exOut        (executed),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .loadInExec   (loadInExec),
        .loadPending  (loadPending)
    );

    // output side: data port and writeback
    memWriteback u_memWriteback (
        .Clock       (Clock),
        .rstN        (rstN),
        .exIn        (executed),
        .dataIn      (dataIn),
        .dataWaitreq (dataWaitreq),
        .dataAddr    (dataAddr),
        .dataOut     (dataOut),
        .readData    (readData),
        .writeData   (writeData),
        .stall       (stall),
        .memFwd      (memFwd),
        .wbOut       (wbOut)
    );

endmodule

// ==== test/cpuMemModel.sv ====
// instruction ROM, data RAM with random wait request, and a log of completed stores
`timescale 1ns/1ps

module cpuMemModel (
    input  logic          Clock,
    input  logic          rstN,
    input  pipePkg::wordT instrAddr,
    input  pipePkg::wordT dataAddr,
    input  pipePkg::wordT dataOut,
    input  logic          readData,
    input  logic          writeData,
    input  int            waitPct,      // chance of wait request per cycle, 0..100
    output pipePkg::wordT instrIn,
    output pipePkg::wordT dataIn,
    output logic          dataWaitreq,
    output int            writeCount    // stores completed since reset
);
    import pipePkg::*;

    localparam int RomWords = 16;
    localparam int RamWords = 256;
    localparam int LogSize  = 8;

    wordT        rom [RomWords];        // program, loaded by the testbench per test
    wordT        ram [RamWords];        // data, low address byte selects the word
    logic [31:0] writeLog [LogSize];    // {address, data} of each completed store
    integer      seed;

    initial begin
        seed        = 32'h8896;
        dataWaitreq = 1'b0;
        for (int i = 0; i < RomWords; i++) begin
            rom[i] = '0;
        end
    end

    // past the end of the program the core fetches nops
    assign instrIn = (instrAddr < RomWords) ? rom[instrAddr[3:0]] : '0;
    assign dataIn  = readData ? ram[dataAddr[7:0]] : '0;

    // a store completes in the cycle its strobe is up and wait request is low
    always @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            writeCount <= 0;
        end else if (writeData && !dataWaitreq) begin
            ram[dataAddr[7:0]] <= dataOut;
            if (writeCount < LogSize) begin
                writeLog[writeCount] <= {dataAddr, dataOut};
            end
            writeCount <= writeCount + 1;
        end
    end

    // redrawn every cycle, also when no access is pending
    always @(posedge Clock) begin
        dataWaitreq <= ({$random(seed)} % 100) < waitPct;
    end

endmodule

// ==== test/cpuCoreTb.sv ====
// cpuCore testbench with clock, reset, test table, program loading, store checks and summary
`timescale 1ns/1ps

module cpuCoreTb;
    import pipePkg::*;

    localparam int NumTests    = 5;
    localparam int ProgWords   = 16;
    localparam int RamWords    = 256;
    localparam int MaxWrites   = 4;
    localparam int ResetCycles = 5;
    localparam int DrainAddr   = ProgWords + 4;  // once fetch gets this far the last store is done
    localparam int WaitLimit   = 1000;           // cycles allowed per wait loop
    localparam logic [15:0] ResetAddr = 16'h0000;  // first fetch address of the core

    // one completed store with the address in the upper half
    typedef struct packed {
        wordT addr;
        wordT data;
    } writeT;

    logic Clock;
    logic rstN;
    wordT instrIn;
    wordT dataIn;
    logic dataWaitreq;
    wordT instrAddr;
    wordT dataAddr;
    wordT dataOut;
    logic readData;
    logic writeData;
    int   waitPct;
    int   writeCount;

    string nameTab   [NumTests];
    wordT  progTab   [NumTests][ProgWords];
    writeT presetTab [NumTests][2];           // data words placed before the run
    writeT expTab    [NumTests][MaxWrites];   // stores in the order they must appear
    int    expCount  [NumTests];
    int    waitTab   [NumTests];              // wait request chance in percent
    logic  resetTab  [NumTests];              // also look at the ports during reset

    int errors;
    int testErrors;
    int failedTests;

    initial begin
        Clock = 1'b0;
        forever begin
            #2 Clock = ~Clock;  // 4 ns period
        end
    end

    cpuCore u_cpuCore (
        .Clock       (Clock),
        .rstN        (rstN),
        .instrIn     (instrIn),
        .dataIn      (dataIn),
        .dataWaitreq (dataWaitreq),
        .instrAddr   (instrAddr),
        .dataAddr    (dataAddr),
        .dataOut     (dataOut),
        .readData    (readData),
        .writeData   (writeData)
    );

    cpuMemModel u_cpuMemModel (
        .Clock       (Clock),
        .rstN        (rstN),
        .instrAddr   (instrAddr),
        .dataAddr    (dataAddr),
        .dataOut     (dataOut),
        .readData    (readData),
        .writeData   (writeData),
        .waitPct     (waitPct),
        .instrIn     (instrIn),
        .dataIn      (dataIn),
        .dataWaitreq (dataWaitreq),
        .writeCount  (writeCount)
    );

    task automatic fillTable();
        // mv r1,#5A  mvt r0,#A5  add r0,r1  mv r2,#20  st r0,[r2]  mv r3,r0  mv r4,#21  st r3,[r4]
        nameTab[0]   = "mv and mvt";
        progTab[0]   = '{16'h125A, 16'h30A5, 16'h4001, 16'h1420, 16'hA002, 16'h0600, 16'h1821,
                         16'hA604, '0, '0, '0, '0, '0, '0, '0, '0};
        expTab[0]    = '{32'h0020_A55A, 32'h0021_A55A, '0, '0};
        expCount[0]  = 2;
        // mv r1,#F3  mv r2,#1D  add r1,r2  sub r1,#5  and r1,#1CE  add r2,r1  mv r3,#40
        // st r1,[r3]  add r3,#1  st r2,[r3]  sub r1,r2  st r1,[r3]
        nameTab[1]   = "forwarding";
        progTab[1]   = '{16'h12F3, 16'h141D, 16'h4202, 16'h7205, 16'hD3CE, 16'h4401, 16'h1640,
                         16'hA203, 16'h5601, 16'hA403, 16'h6202, 16'hA203, '0, '0, '0, '0};
        expTab[1]    = '{32'h0040_010A, 32'h0041_0127, 32'h0041_FFE3, '0};
        expCount[1]  = 3;
        // mv r1,#30  mv r2,#11  ld r3,[r1]  add r3,r2  st r3,[r1]  add r1,#1  ld r4,[r1]
        // st r2,[r4]  ld r5,[r1]  st r5,[r4]
        nameTab[2]   = "load use";
        progTab[2]   = '{16'h1230, 16'h1411, 16'h8601, 16'h4602, 16'hA601, 16'h5201, 16'h8801,
                         16'hA404, 16'h8A01, 16'hAA04, '0, '0, '0, '0, '0, '0};
        presetTab[2] = '{32'h0030_1234, 32'h0031_0050};
        expTab[2]    = '{32'h0030_1245, 32'h0050_0011, 32'h0050_0050, '0};
        expCount[2]  = 3;
        // mv r1,#60  mv r2,#77  b +2  st  st  sub r2,#77  beq +2  st  st  bne +1
        // st r1,[r1]  mv r3,#AB  st r3,[r1]   every skipped store is st r2,[r1]
        nameTab[3]   = "branches";
        progTab[3]   = '{16'h1260, 16'h1477, 16'h2002, 16'hA401, 16'hA401, 16'h7477, 16'h2202,
                         16'hA401, 16'hA401, 16'h2401, 16'hA201, 16'h16AB, 16'hA601, '0, '0, '0};
        expTab[3]    = '{32'h0060_0060, 32'h0060_00AB, '0, '0};
        expCount[3]  = 2;
        // forwarding program again under random wait request
        nameTab[4]   = "back-pressure";
        progTab[4]   = progTab[1];
        expTab[4]    = expTab[1];
        expCount[4]  = expCount[1];
        for (int t = 0; t < NumTests; t++) begin
            waitTab[t]  = (t == 4) ? 50 : 0;
            resetTab[t] = (t == 0);
            if (t != 2) begin
                presetTab[t] = '{'0, '0};  // lands on address 0 which no test reads
            end
        end
    endtask

    task automatic checkResetState();
        @(negedge Clock);
        assert (readData == 1'b0) else begin
            $display("MISMATCH at %0t: readData expected 0 got %b", $time, readData);
            testErrors++;
        end
        assert (writeData == 1'b0) else begin
            $display("MISMATCH at %0t: writeData expected 0 got %b", $time, writeData);
            testErrors++;
        end
        assert (instrAddr == ResetAddr) else begin
            $display("MISMATCH at %0t: instrAddr expected %h got %h",
                     $time, ResetAddr, instrAddr);
            testErrors++;
        end
    endtask

    // program and data go in while the core is held in reset
    task automatic startTest(input int t);
        @(posedge Clock);
        rstN    <= 1'b0;
        waitPct <= waitTab[t];
        for (int i = 0; i < ProgWords; i++) begin
            u_cpuMemModel.rom[i] <= progTab[t][i];
        end
        for (int i = 0; i < RamWords; i++) begin
            u_cpuMemModel.ram[i] <= {i[7:0], ~i[7:0]};  // address byte above its inverse
        end
        for (int i = 0; i < 2; i++) begin
            u_cpuMemModel.ram[presetTab[t][i].addr[7:0]] <= presetTab[t][i].data;
        end
        repeat (ResetCycles - 1) @(posedge Clock);
        if (resetTab[t]) begin
            checkResetState();
        end
        @(posedge Clock);
        rstN <= 1'b1;
    endtask

    task automatic runTest(input int t);
        int    cycles;
        int    k;
        writeT got;
        testErrors = 0;
        startTest(t);
        cycles = 0;
        while (writeCount < expCount[t] && cycles < WaitLimit) begin
            @(negedge Clock);
            cycles++;
        end
        if (writeCount < expCount[t]) begin
            $display("test %0d timed out with %0d of %0d stores seen", t, writeCount, expCount[t]);
            testErrors++;
        end
        // squashed or repeated stores would still show up while the tail drains
        cycles = 0;
        while (instrAddr < DrainAddr && cycles < WaitLimit) begin
            @(negedge Clock);
            cycles++;
        end
        if (instrAddr < DrainAddr) begin
            $display("test %0d timed out before fetch passed the end of the program", t);
            testErrors++;
        end
        assert (writeCount == expCount[t]) else begin
            $display("MISMATCH at %0t: writeCount expected %0d got %0d",
                     $time, expCount[t], writeCount);
            testErrors++;
        end
        for (k = 0; k < expCount[t] && k < writeCount; k++) begin
            got = u_cpuMemModel.writeLog[k];
            assert (got.addr == expTab[t][k].addr) else begin
                $display("MISMATCH at %0t: dataAddr expected %h got %h",
                         $time, expTab[t][k].addr, got.addr);
                testErrors++;
            end
            assert (got.data == expTab[t][k].data) else begin
                $display("MISMATCH at %0t: dataOut expected %h got %h",
                         $time, expTab[t][k].data, got.data);
                testErrors++;
            end
        end
        errors += testErrors;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test %0d %s: %s, %0d errors", t, nameTab[t],
                 (testErrors == 0) ? "ok" : "FAILED", testErrors);
    endtask

    initial begin
        int t;
        rstN        <= 1'b0;
        waitPct     <= 0;
        errors      = 0;
        failedTests = 0;
        fillTable();
        for (t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NumTests, failedTests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchDecode.sv
logic/regFile.sv
logic/execUnit.sv
logic/memWriteback.sv
logic/cpuCore.sv
test/cpuMemModel.sv
test/cpuCoreTb.sv
